// File: Bender.yml
package:
  name: mipsSingleCycle

sources:
  - include_dirs:
      - include
    files:
      - verilog/mipsPkg.sv
      - verilog/aluUnit.sv
      - verilog/instrDecoder.sv
      - verilog/regFile.sv
      - verilog/wordMemory.sv
      - verilog/mipsCore.sv
      - verilog/mipsTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/mipsTb.sv

// File: sim.f
+incdir+include
verilog/mipsPkg.sv
verilog/aluUnit.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/wordMemory.sv
verilog/mipsCore.sv
verilog/mipsTop.sv
verif/mipsTb.sv

// File: include/mipsModel.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

//////////////////////////////////////////////////
// Program encoders

function automatic mipsPkg::word_t encR(mipsPkg::funct_t fn, mipsPkg::regAddr_t rd,
                                        mipsPkg::regAddr_t rs, mipsPkg::regAddr_t rt);
    mipsPkg::instr_t ins;
    ins.rFields = '{opcode: mipsPkg::opR, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: fn};
    return ins;
endfunction

// Operand order as in addi rt, rs, imm and lw rt, imm(rs)
function automatic mipsPkg::word_t encI(mipsPkg::opcode_t op, mipsPkg::regAddr_t rt,
                                        mipsPkg::regAddr_t rs, logic [15:0] imm);
    mipsPkg::instr_t ins;
    ins.iFields = '{opcode: op, rs: rs, rt: rt, imm: imm};
    return ins;
endfunction

function automatic mipsPkg::word_t encJ(logic [25:0] target); // Target as word index
    mipsPkg::instr_t ins;
    ins.jFields = '{opcode: mipsPkg::opJ, target: target};
    return ins;
endfunction

//////////////////////////////////////////////////
// Instruction-level model that stops when the next PC equals the current one

function automatic void mipsModelRun(input mipsPkg::word_t prog[], input mipsPkg::word_t data[],
                                     input int maxSteps, output mipsPkg::word_t expAddr[$],
                                     output mipsPkg::word_t expData[$]);
    mipsPkg::word_t regs [32];
    mipsPkg::word_t mem [];
    mipsPkg::word_t pc, nextPc, a, b, imm, diff;
    mipsPkg::instr_t ins;
    mem = data;
    regs = '{default: '0};
    pc = '0;
    expAddr.delete();
    expData.delete();
    for (int step = 0; step < maxSteps; step++) begin
        ins = prog[(pc >> 2) % prog.size()];
        a = regs[ins.rFields.rs];
        b = regs[ins.rFields.rt];
        imm = {{16{ins.iFields.imm[15]}}, ins.iFields.imm};
        diff = a - b;
        nextPc = pc + 4;
        case (ins.rFields.opcode)
            mipsPkg::opR: begin
                case (ins.rFields.funct)
                    mipsPkg::fnAdd: regs[ins.rFields.rd] = a + b;
                    mipsPkg::fnSub: regs[ins.rFields.rd] = diff;
                    mipsPkg::fnAnd: regs[ins.rFields.rd] = a & b;
                    mipsPkg::fnOr:  regs[ins.rFields.rd] = a | b;
                    mipsPkg::fnSlt: regs[ins.rFields.rd] = {31'd0, diff[31]}; // Sign of a - b
                    default: ;
                endcase
            end
            mipsPkg::opAddi: regs[ins.iFields.rt] = a + imm;
            mipsPkg::opLw:   regs[ins.iFields.rt] = mem[((a + imm) >> 2) % mem.size()];
            mipsPkg::opSw: begin
                mem[((a + imm) >> 2) % mem.size()] = b;
                expAddr.push_back(a + imm);
                expData.push_back(b);
            end
            mipsPkg::opBeq: if (diff == '0) nextPc = pc + 4 + (imm << 2);
            mipsPkg::opJ:   nextPc = {nextPc[31:28], ins.jFields.target, 2'b00};
            default: ;
        endcase
        regs[0] = '0; // Register 0 stays zero
        if (nextPc == pc) break;
        pc = nextPc;
    end
endfunction

`endif

// File: verif/mipsTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsTb;
    import mipsPkg::*;

    `include "mipsModel.svh"

    localparam int memAddrBits = 8;
    localparam int memWords = 2**memAddrBits;
    localparam int clkPeriod = 100;
    localparam int resetCycles = 8;
    localparam int maxRunCycles = 400;
    localparam int drainCycles = 12;   // Quiet cycles that catch extra stores
    localparam int modelSteps = 1000;
    localparam int numTests = 4;
    localparam int testCycles = memWords + 64 + resetCycles + maxRunCycles + drainCycles;
    localparam int watchdogCycles = numTests * testCycles + 50;

    logic  clk;
    logic  reset;
    logic  loadWe;
    logic  loadToData;
    logic  [7:0] loadAddr;
    word_t loadData;
    logic  storeValid;
    word_t storeAddr;
    word_t storeData;

    word_t prog[];
    word_t data[];
    word_t expAddrQ[$];
    word_t expDataQ[$];
    word_t rngState = 32'h06543da2;

    int addrErrors = 0;
    int dataErrors = 0;
    int otherErrors = 0;
    int expCount = 0;
    int storesSeen = 0;
    int runCycle = 0;
    int firstStoreCycle = -1;

    mipsTop #(.imemAddrBits(memAddrBits), .dmemAddrBits(memAddrBits)) dut0 (
        .clk(clk), .reset(reset), .loadWe(loadWe), .loadToData(loadToData),
        .loadAddr(loadAddr), .loadData(loadData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers

    function automatic word_t nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic word_t fillWord(logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h3c, idx + 8'h11}; // Every byte tied to the index
    endfunction

    task automatic fillData();
        data = new[memWords];
        for (int i = 0; i < memWords; i++) begin
            data[i] = fillWord(8'(i));
        end
    endtask

    task automatic checkAddr(input word_t got, input word_t exp);
        if (got !== exp) begin
            addrErrors++;
            $display("CHECK FAILED storeAddr: got %h, expected %h", got, exp);
        end
    endtask

    task automatic checkData(input word_t got, input word_t exp);
        if (got !== exp) begin
            dataErrors++;
            $display("CHECK FAILED storeData: got %h, expected %h", got, exp);
        end
    endtask

    task automatic loadImage(input logic toData, input word_t img[]);
        for (int i = 0; i < img.size(); i++) begin
            @(posedge clk);
            loadWe <= 1'b1;
            loadToData <= toData;
            loadAddr <= 8'(i);
            loadData <= img[i];
        end
        @(posedge clk);
        loadWe <= 1'b0;
    endtask

    // Reset, load both images, release and wait for every predicted store
    task automatic runTest(input string name);
        int waited;
        @(posedge clk);
        reset <= 1'b1;
        mipsModelRun(prog, data, modelSteps, expAddrQ, expDataQ);
        expCount = expAddrQ.size();
        loadImage(1'b0, prog);
        loadImage(1'b1, data);
        repeat (resetCycles) @(posedge clk);
        storesSeen = 0;
        runCycle = 0;
        firstStoreCycle = -1;
        reset <= 1'b0;
        waited = 0;
        while (storesSeen < expCount && waited < maxRunCycles) begin
            @(posedge clk);
            waited++;
        end
        if (storesSeen < expCount) begin
            otherErrors++;
            $display("ERROR: %s saw only %0d of %0d stores within %0d cycles",
                     name, storesSeen, expCount, maxRunCycles);
        end
        repeat (drainCycles) @(posedge clk);
        $display("%s: %0d stores compared", name, storesSeen);
    endtask

    //////////////////////////////////////////////////
    // Store comparison at the falling edge

    always @(negedge clk) begin
        if (reset) begin
            if (storeValid) begin
                otherErrors++;
                $display("ERROR: store pulse while reset is high");
            end
        end else begin
            if (storeValid) begin
                if (storesSeen == 0) begin
                    firstStoreCycle = runCycle;
                end
                if (expAddrQ.size() == 0) begin
                    otherErrors++;
                    $display("ERROR: store to %h that the model does not predict", storeAddr);
                end else begin
                    checkAddr(storeAddr, expAddrQ.pop_front());
                    checkData(storeData, expDataQ.pop_front());
                end
                storesSeen++;
            end
            runCycle++;
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: run exceeded %0d clock cycles", watchdogCycles);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Tests

    initial begin
        reset = 1'b1;
        loadWe = 1'b0;
        loadToData = 1'b0;
        loadAddr = '0;
        loadData = '0;

        // Store first, negative offsets, register 0
        fillData();
        prog = new[9];
        prog[0] = encI(opSw, 5'd0, 5'd0, 16'h0040);
        prog[1] = encI(opAddi, 5'd0, 5'd0, 16'h0055);   // Ignored write
        prog[2] = encI(opAddi, 5'd1, 5'd0, 16'h0100);
        prog[3] = encI(opAddi, 5'd2, 5'd0, 16'hfffd);   // -3
        prog[4] = encI(opSw, 5'd2, 5'd1, 16'hfff8);     // -8(r1)
        prog[5] = encI(opLw, 5'd3, 5'd1, 16'hfff8);
        prog[6] = encI(opSw, 5'd3, 5'd1, 16'hfffc);     // -4(r1)
        prog[7] = encI(opSw, 5'd0, 5'd1, 16'h0000);
        prog[8] = encJ(26'd8);
        runTest("storeFirst");
        if (firstStoreCycle != 0) begin
            otherErrors++;
            $display("ERROR: first store came %0d cycles after reset, not in the first cycle",
                     firstStoreCycle);
        end

        // Fibonacci terms of n read from word 0
        fillData();
        data[0] = 32'd12;
        prog = new[13];
        prog[0] = encI(opLw, 5'd1, 5'd0, 16'd0);
        prog[1] = encI(opAddi, 5'd2, 5'd0, 16'd0);
        prog[2] = encI(opAddi, 5'd3, 5'd0, 16'd1);
        prog[3] = encI(opAddi, 5'd4, 5'd0, 16'h0100);  // Output pointer
        prog[4] = encI(opBeq, 5'd0, 5'd1, 16'd7);       // Done when n is zero
        prog[5] = encI(opSw, 5'd2, 5'd4, 16'd0);
        prog[6] = encR(fnAdd, 5'd5, 5'd2, 5'd3);
        prog[7] = encR(fnAdd, 5'd2, 5'd3, 5'd0);
        prog[8] = encR(fnAdd, 5'd3, 5'd5, 5'd0);
        prog[9] = encI(opAddi, 5'd4, 5'd4, 16'd4);
        prog[10] = encI(opAddi, 5'd1, 5'd1, 16'hffff);
        prog[11] = encJ(26'd4);
        prog[12] = encJ(26'd12);
        runTest("fibonacci");

        // Random operand pairs through every R-type operation
        fillData();
        data[0] = nextRandom() | 32'h80000000;         // Negative
        data[1] = nextRandom() & 32'h7fffffff;
        data[2] = nextRandom();
        data[3] = data[2];                              // Equal pair
        for (int i = 4; i < 8; i++) begin
            data[i] = nextRandom();
        end
        prog = new[23];
        prog[0] = encI(opAddi, 5'd6, 5'd0, 16'd0);
        prog[1] = encI(opAddi, 5'd7, 5'd0, 16'h0200);
        prog[2] = encI(opAddi, 5'd8, 5'd0, 16'd4);     // Pair count
        prog[3] = encI(opLw, 5'd1, 5'd6, 16'd0);
        prog[4] = encI(opLw, 5'd2, 5'd6, 16'd4);
        prog[5] = encR(fnAdd, 5'd3, 5'd1, 5'd2);
        prog[6] = encI(opSw, 5'd3, 5'd7, 16'd0);
        prog[7] = encR(fnSub, 5'd3, 5'd1, 5'd2);
        prog[8] = encI(opSw, 5'd3, 5'd7, 16'd4);
        prog[9] = encR(fnAnd, 5'd3, 5'd1, 5'd2);
        prog[10] = encI(opSw, 5'd3, 5'd7, 16'd8);
        prog[11] = encR(fnOr, 5'd3, 5'd1, 5'd2);
        prog[12] = encI(opSw, 5'd3, 5'd7, 16'd12);
        prog[13] = encR(fnSlt, 5'd3, 5'd1, 5'd2);
        prog[14] = encI(opSw, 5'd3, 5'd7, 16'd16);
        prog[15] = encR(fnSlt, 5'd3, 5'd2, 5'd1);
        prog[16] = encI(opSw, 5'd3, 5'd7, 16'd20);
        prog[17] = encI(opAddi, 5'd6, 5'd6, 16'd8);
        prog[18] = encI(opAddi, 5'd7, 5'd7, 16'd24);
        prog[19] = encI(opAddi, 5'd8, 5'd8, 16'hffff);
        prog[20] = encI(opBeq, 5'd0, 5'd8, 16'd1);
        prog[21] = encJ(26'd3);
        prog[22] = encJ(26'd22);
        runTest("aluRandom");

        // Branches taken and not taken, jump over a store
        fillData();
        prog = new[15];
        prog[0] = encI(opAddi, 5'd1, 5'd0, 16'd5);
        prog[1] = encI(opAddi, 5'd2, 5'd0, 16'd5);
        prog[2] = encI(opAddi, 5'd3, 5'd0, 16'd7);
        prog[3] = encI(opBeq, 5'd2, 5'd1, 16'd1);       // Taken
        prog[4] = encI(opSw, 5'd0, 5'd0, 16'h0300);
        prog[5] = encI(opAddi, 5'd4, 5'd0, 16'h0011);
        prog[6] = encI(opSw, 5'd4, 5'd0, 16'h0304);
        prog[7] = encI(opBeq, 5'd3, 5'd1, 16'd1);       // Not taken
        prog[8] = encI(opAddi, 5'd4, 5'd0, 16'h0022);
        prog[9] = encI(opSw, 5'd4, 5'd0, 16'h0308);
        prog[10] = encJ(26'd12);
        prog[11] = encI(opSw, 5'd1, 5'd0, 16'h030c);
        prog[12] = encI(opAddi, 5'd4, 5'd0, 16'h0033);
        prog[13] = encI(opSw, 5'd4, 5'd0, 16'h0310);
        prog[14] = encI(opBeq, 5'd0, 5'd0, 16'hffff);  // Branch to itself
        runTest("branchJump");

        $display("Error counts: storeAddr %0d, storeData %0d, other %0d",
                 addrErrors, dataErrors, otherErrors);
        if (addrErrors + dataErrors + otherErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire mipsPkg::aluOp_t aluOp,
    input  wire mipsPkg::word_t  srcA,
    input  wire mipsPkg::word_t  srcB,
    output mipsPkg::word_t       result,
    output logic                 zero
);
    import mipsPkg::*;

    word_t diff;

    // Shared by sub and slt
    assign diff = srcA - srcB;

    always_comb begin
        case (aluOp)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = diff;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, diff[dataWidth-1]}; // Sign of difference
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // Used by beq

endmodule

`default_nettype wire

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire mipsPkg::instr_t instr,
    output logic                 regDst,
    output logic                 aluSrc,
    output logic                 memToReg,
    output logic                 regWrite,
    output logic                 memWrite,
    output logic                 branch,
    output logic                 jump,
    output mipsPkg::aluOp_t      aluOp
);
    import mipsPkg::*;

    always_comb begin
        regDst   = 1'b0;
        aluSrc   = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        aluOp    = aluAdd; // Address and addi arithmetic

        case (instr.rFields.opcode)
            opR: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (instr.rFields.funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: regWrite = 1'b0; // Unknown funct is a no-op
                endcase
            end
            opLw: begin
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            opSw: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opBeq: begin
                branch = 1'b1;
                aluOp  = aluSub; // Equal when difference is zero
            end
            opAddi: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            opJ:     jump = 1'b1;
            default: ;
        endcase
    end

    // One instruction never writes both register file and memory
    always_comb begin
        assert final (!(regWrite && memWrite))
            else $error("regWrite and memWrite both high");
    end

endmodule

`default_nettype wire

// File: verilog/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire mipsPkg::word_t    instrWord,
    output mipsPkg::instr_t        instr,
    input  wire logic              regDst,
    input  wire logic              aluSrc,
    input  wire logic              memToReg,
    input  wire logic              regWriteCtl,
    input  wire logic              memWriteCtl,
    input  wire logic              branch,
    input  wire logic              jump,
    output mipsPkg::word_t         pc,
    output mipsPkg::word_t         srcA,
    output mipsPkg::word_t         srcB,
    input  wire mipsPkg::word_t    aluResult,
    input  wire logic              zero,
    output mipsPkg::regAddr_t      readReg1,
    output mipsPkg::regAddr_t      readReg2,
    output mipsPkg::regAddr_t      writeReg,
    output mipsPkg::word_t         writeData,
    output logic                   regWrite,
    input  wire mipsPkg::word_t    readData1,
    input  wire mipsPkg::word_t    readData2,
    input  wire mipsPkg::word_t    memReadData,
    output logic                   memWrite
);
    import mipsPkg::*;

    word_t signImm;
    word_t pcPlus4;
    word_t branchTarget;
    word_t jumpTarget;
    word_t pcNext;

    assign instr = instrWord;
    assign signImm = {{(dataWidth-16){instr.iFields.imm[15]}}, instr.iFields.imm};

    //////////////////////////////////////////////////
    // Next PC

    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[dataWidth-3:0], 2'b00}; // Offset in words
    assign jumpTarget = {pcPlus4[31:28], instr.jFields.target, 2'b00};

    always_comb begin
        if (jump) begin
            pcNext = jumpTarget;
        end else if (branch && zero) begin
            pcNext = branchTarget; // beq taken
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    //////////////////////////////////////////////////
    // Operands and writeback

    assign readReg1 = instr.rFields.rs;
    assign readReg2 = instr.rFields.rt;
    assign writeReg = regDst ? instr.rFields.rd : instr.rFields.rt; // rd for R-type

    assign srcA = readData1;
    assign srcB = aluSrc ? signImm : readData2;

    assign writeData = memToReg ? memReadData : aluResult;

    // Nothing architectural changes while the images load
    assign regWrite = regWriteCtl & ~reset;
    assign memWrite = memWriteCtl & ~reset;

endmodule

`default_nettype wire

// File: verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    //////////////////////////////////////////////////
    // Encodings

    typedef enum logic [5:0] {
        opR    = 6'b000000,
        opJ    = 6'b000010,
        opBeq  = 6'b000100,
        opAddi = 6'b001000,
        opLw   = 6'b100011,
        opSw   = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } funct_t;

    // Bit 2 selects the inverted operand for the adder
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOp_t;

    //////////////////////////////////////////////////
    // Instruction word views

    typedef struct packed {
        opcode_t    opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rType_t;

    typedef struct packed {
        opcode_t     opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm;
    } iType_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target; // Word index within the 256 MB region
    } jType_t;

    typedef union packed {
        rType_t rFields;
        iType_t iFields;
        jType_t jFields;
    } instr_t;

endpackage

`default_nettype wire

// File: verilog/mipsTop.sv
`timescale 1ns/1ps
`default_nettype none

module mipsTop #(
    parameter int imemAddrBits = 8,
    parameter int dmemAddrBits = 8
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           loadWe,
    input  wire logic           loadToData,
    input  wire logic [7:0]     loadAddr,
    input  wire mipsPkg::word_t loadData,
    output logic                storeValid,
    output mipsPkg::word_t      storeAddr,
    output mipsPkg::word_t      storeData
);
    import mipsPkg::*;

    instr_t   instr;
    word_t    instrWord, pc;
    word_t    srcA, srcB, aluResult;
    word_t    readData1, readData2, writeData, memReadData;
    regAddr_t readReg1, readReg2, writeReg;
    aluOp_t   aluOp;
    logic     zero, regWrite, memWrite;
    logic     regDst, aluSrc, memToReg, ctlRegWrite, ctlMemWrite, branch, jump;
    logic     imemLoadWe, dmemLoadWe;
    logic [imemAddrBits-1:0] imemLoadAddr;
    logic [dmemAddrBits-1:0] dmemLoadAddr;

    // Load steering
    assign imemLoadWe = loadWe & ~loadToData;
    assign dmemLoadWe = loadWe & loadToData;
    assign imemLoadAddr = imemAddrBits'(loadAddr);
    assign dmemLoadAddr = dmemAddrBits'(loadAddr);

    // Store port mirrors the data memory write
    assign storeValid = memWrite;
    assign storeAddr = aluResult;
    assign storeData = readData2;

    mipsCore core0 (
        .clk(clk), .reset(reset), .instrWord(instrWord), .instr(instr),
        .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
        .regWriteCtl(ctlRegWrite), .memWriteCtl(ctlMemWrite),
        .branch(branch), .jump(jump), .pc(pc), .srcA(srcA), .srcB(srcB),
        .aluResult(aluResult), .zero(zero),
        .readReg1(readReg1), .readReg2(readReg2), .writeReg(writeReg),
        .writeData(writeData), .regWrite(regWrite),
        .readData1(readData1), .readData2(readData2),
        .memReadData(memReadData), .memWrite(memWrite)
    );

    instrDecoder decoder0 (
        .instr(instr), .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
        .regWrite(ctlRegWrite), .memWrite(ctlMemWrite),
        .branch(branch), .jump(jump), .aluOp(aluOp)
    );

    aluUnit alu0 (
        .aluOp(aluOp), .srcA(srcA), .srcB(srcB), .result(aluResult), .zero(zero)
    );

    regFile regs0 (
        .clk(clk), .reset(reset), .regWrite(regWrite),
        .readReg1(readReg1), .readReg2(readReg2), .writeReg(writeReg),
        .writeData(writeData), .readData1(readData1), .readData2(readData2)
    );

    wordMemory #(.addrBits(imemAddrBits)) imem (
        .clk(clk), .reset(reset), .readAddr(pc), .readData(instrWord),
        .writeEn(1'b0), .writeAddr('0), .writeData('0), // Program is read-only
        .loadWe(imemLoadWe), .loadAddr(imemLoadAddr), .loadData(loadData)
    );

    wordMemory #(.addrBits(dmemAddrBits)) dmem (
        .clk(clk), .reset(reset), .readAddr(aluResult), .readData(memReadData),
        .writeEn(memWrite), .writeAddr(aluResult), .writeData(readData2),
        .loadWe(dmemLoadWe), .loadAddr(dmemLoadAddr), .loadData(loadData)
    );

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              regWrite,
    input  wire mipsPkg::regAddr_t readReg1,
    input  wire mipsPkg::regAddr_t readReg2,
    input  wire mipsPkg::regAddr_t writeReg,
    input  wire mipsPkg::word_t    writeData,
    output mipsPkg::word_t         readData1,
    output mipsPkg::word_t         readData2
);
    import mipsPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && writeReg != '0) begin // Register 0 ignores writes
            regs[writeReg] <= writeData;
        end
    end

    assign readData1 = regs[readReg1];
    assign readData2 = regs[readReg2];

    // Register 0 reads zero whatever was written to it
    assert property (@(posedge clk) disable iff (reset)
        readReg1 == '0 |-> readData1 == '0)
        else $error("register 0 read nonzero");

endmodule

`default_nettype wire

// File: verilog/wordMemory.sv
`timescale 1ns/1ps
`default_nettype none

module wordMemory #(
    parameter int addrBits = 8
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire mipsPkg::word_t      readAddr,
    output mipsPkg::word_t           readData,
    input  wire logic                writeEn,
    input  wire mipsPkg::word_t      writeAddr,
    input  wire mipsPkg::word_t      writeData,
    input  wire logic                loadWe,
    input  wire logic [addrBits-1:0] loadAddr,
    input  wire mipsPkg::word_t      loadData
);
    import mipsPkg::*;

    word_t mem [2**addrBits];

    assign readData = mem[readAddr[addrBits+1:2]]; // Byte address to word index

    always_ff @(posedge clk) begin
        if (loadWe) begin
            mem[loadAddr] <= loadData; // Image load by word index
        end else if (writeEn) begin
            mem[writeAddr[addrBits+1:2]] <= writeData;
        end
    end

    // Image loads belong to the reset phase only
    assert property (@(posedge clk) loadWe |-> reset)
        else $error("load strobe outside reset");

endmodule

`default_nettype wire
